// File: intUnit.sv
`default_nettype none

`include "intUnit_config.svh"

module intUnit (
   input  logic                 MCLK,
   input  logic                 rstN,
   input  logic                 intAck,
   input  logic [`NUM_SRC-1:0]  intSrc,
   output logic                 deviceReset,
   output logic                 intReq,
   output intUnitPkg::vector_t  intVector,
   output logic [`NUM_SRC-1:0]  intClr
);
   import intUnitPkg::*;

   intLink_t chainLink;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Device reset
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   resetSequencer resetSeq (
      .MCLK        (MCLK),
      .rstN        (rstN),
      .deviceReset (deviceReset)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Priority chain
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   interruptChain chain (
      .MCLK        (MCLK),
      .deviceReset (deviceReset),
      .intSrc      (intSrc),
      .intAck      (intAck),
      .intLink     (chainLink),
      .intClr      (intClr)
   );

   assign intReq    = chainLink.req;
   assign intVector = chainLink.vector;   // Reads zero when nothing is pending

endmodule

`default_nettype wire

// File: intUnitPkg.sv
`default_nettype none

`include "intUnit_config.svh"

package intUnitPkg;

   typedef logic [`VECTOR_W-1:0] vector_t;

   // One hop of the daisy chain, moving toward the CPU
   typedef struct packed {
      logic    req;
      vector_t vector;
   } intLink_t;

   typedef enum logic [1:0] {
      HOLD,      // rstN is low
      STRETCH,   // Counting out the reset stretch
      RUN
   } resetState_t;

endpackage

`default_nettype wire

// File: intUnit_config.svh
`ifndef INTUNIT_CONFIG_SVH
`define INTUNIT_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt chain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define NUM_SRC      8   // Peripheral interrupt sources, stage 0 wins
`define VECTOR_W     6   // Width of the vector index sent to the CPU
`define VECTOR_TOP   60  // Index of stage 0, later stages count down

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset stretch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RESET_DELAY  16  // Clocks deviceReset is held after rstN rises
`define DELAY_W      5   // Must hold RESET_DELAY - 1

`endif

// File: intUnit_sva.sv
`default_nettype none

`include "intUnit_config.svh"

module intUnit_sva (
   input logic                MCLK,
   input logic                rstN,
   input logic                intAck,
   input logic                deviceReset,
   input logic                intReq,
   input logic [`NUM_SRC-1:0] intClr
);

   // Only one stage is served per acknowledge
   clrOneHot: assert property (@(posedge MCLK) disable iff (!rstN) $onehot0(intClr))
      else $error("intClr has %0d bits set", $countones(intClr));

   clrNeedsAck: assert property (@(posedge MCLK) disable iff (!rstN) (|intClr) |-> intAck)
      else $error("intClr is 0x%0h without intAck", intClr);

   // The chain is held empty through the reset stretch
   noReqInReset: assert property (@(posedge MCLK) disable iff (!rstN) deviceReset |-> !intReq)
      else $error("intReq is high while deviceReset is high");

endmodule

bind intUnit intUnit_sva intUnitChecks (
   .MCLK        (MCLK),
   .rstN        (rstN),
   .intAck      (intAck),
   .deviceReset (deviceReset),
   .intReq      (intReq),
   .intClr      (intClr)
);

`default_nettype wire

// File: interruptChain.sv
`default_nettype none

`include "intUnit_config.svh"

module interruptChain (
   input  logic                  MCLK,
   input  logic                  deviceReset,
   input  logic [`NUM_SRC-1:0]   intSrc,
   input  logic                  intAck,
   output intUnitPkg::intLink_t  intLink,
   output logic [`NUM_SRC-1:0]   intClr
);
   import intUnitPkg::*;

   // Index n is the link entering stage n from below, index 0 goes to the CPU
   intLink_t            linkBus [`NUM_SRC:0];
   // Index n is the acknowledge arriving at stage n from above
   logic [`NUM_SRC:0]   ackBus;

   assign linkBus[`NUM_SRC] = '{req: 1'b0, vector: '0};   // Empty end of chain
   assign ackBus[0]         = intAck;
   assign intLink           = linkBus[0];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stages, highest priority first
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   genvar i;
   generate
      for (i = 0; i < `NUM_SRC; i++) begin : genStage
         interruptStage #(
            .INDEX (vector_t'(`VECTOR_TOP - i))
         ) stage (
            .MCLK        (MCLK),
            .deviceReset (deviceReset),
            .src         (intSrc[i]),
            .ackIn       (ackBus[i]),
            .linkIn      (linkBus[i+1]),
            .linkOut     (linkBus[i]),
            .ackThru     (ackBus[i+1]),
            .clr         (intClr[i])
         );
      end
   endgenerate

   // An acknowledge that reaches the far end found nothing pending

endmodule

`default_nettype wire

// File: interruptStage.sv
`default_nettype none

module interruptStage #(
   parameter intUnitPkg::vector_t INDEX = '0
) (
   input  logic                 MCLK,
   input  logic                 deviceReset,
   input  logic                 src,
   input  logic                 ackIn,
   input  intUnitPkg::intLink_t linkIn,
   output intUnitPkg::intLink_t linkOut,
   output logic                 ackThru,
   output logic                 clr
);
   import intUnitPkg::*;

   logic pending;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Pending flag
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge MCLK) begin
      if (deviceReset) begin
         pending <= 1'b0;
      end
      else if (ackIn && pending) begin
         pending <= 1'b0;                     // Acknowledge beats a new flag
      end
      else if (src) begin
         pending <= 1'b1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Chain links
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      if (pending) begin
         linkOut.req    = 1'b1;
         linkOut.vector = INDEX;              // Masks anything further down
      end
      else begin
         linkOut = linkIn;
      end
   end

   assign clr     = ackIn & pending;          // This stage is the one being served
   assign ackThru = ackIn & ~pending;

endmodule

`default_nettype wire

// File: list.f
+incdir+.
intUnitPkg.sv
resetDelayCounter.sv
resetSequencer.sv
interruptStage.sv
interruptChain.sv
intUnit.sv
intUnit_sva.sv
tb_intUnit.sv

// File: resetDelayCounter.sv
`default_nettype none

`include "intUnit_config.svh"

module resetDelayCounter (
   input  logic MCLK,
   input  logic rstN,
   input  logic run,
   output logic done
);

   localparam logic [`DELAY_W-1:0] LAST_COUNT = `DELAY_W'(`RESET_DELAY - 1);

   logic [`DELAY_W-1:0] count;

   always_ff @(posedge MCLK or negedge rstN) begin
      if (!rstN) begin
         count <= '0;
      end
      else if (!run) begin
         count <= '0;                     // Idle counter sits at zero
      end
      else if (count != LAST_COUNT) begin
         count <= count + 1'b1;
      end
   end

   // Count saturates at the last value, so done stays up while run does
   assign done = (count == LAST_COUNT);

endmodule

`default_nettype wire

// File: resetSequencer.sv
`default_nettype none

module resetSequencer (
   input  logic MCLK,
   input  logic rstN,
   output logic deviceReset
);
   import intUnitPkg::*;

   resetState_t state;
   resetState_t stateNext;
   logic        delayRun;
   logic        delayDone;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stretch timer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign delayRun = (state == STRETCH);

   resetDelayCounter delayCounter (
      .MCLK (MCLK),
      .rstN (rstN),
      .run  (delayRun),
      .done (delayDone)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // State machine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      stateNext = state;
      unique case (state)
         HOLD: begin
            stateNext = STRETCH;              // First clock seen with rstN high
         end
         STRETCH: begin
            if (delayDone) begin
               stateNext = RUN;
            end
         end
         RUN: begin
            stateNext = RUN;                  // Only rstN brings it back
         end
         default: begin
            stateNext = HOLD;
         end
      endcase
   end

   always_ff @(posedge MCLK or negedge rstN) begin
      if (!rstN) begin
         state       <= HOLD;
         deviceReset <= 1'b1;                 // Asserted at once, no clock needed
      end
      else begin
         state       <= stateNext;
         deviceReset <= (stateNext != RUN);   // Registered so it drops glitch free
      end
   end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the interrupt unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_intUnit \
   -Mdir "$BUILD_DIR" \
   -o tb_intUnit \
   -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build did not succeed"
   exit 1
fi

"$BUILD_DIR/tb_intUnit" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qxF "*** PASSED ***" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_intUnit.sv
`default_nettype none

`include "intUnit_config.svh"

module tb_intUnit;
   import intUnitPkg::*;

   localparam int PERIOD = 40;

   logic                MCLK;
   logic                rstN;
   logic                intAck;
   logic [`NUM_SRC-1:0] intSrc;
   logic                deviceReset;
   logic                intReq;
   vector_t             intVector;
   logic [`NUM_SRC-1:0] intClr;

   logic [`NUM_SRC-1:0] modelPend;        // Pending bits as the testbench sees them
   int                  errCount = 0;
   int                  testCount = 0;
   int                  testErrStart = 0;

   intUnit DUT (
      .MCLK        (MCLK),
      .rstN        (rstN),
      .intAck      (intAck),
      .intSrc      (intSrc),
      .deviceReset (deviceReset),
      .intReq      (intReq),
      .intVector   (intVector),
      .intClr      (intClr)
   );

   initial begin
      MCLK = 1'b0;
      forever #(PERIOD/2) MCLK = ~MCLK;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic vector_t refVector(input logic [`NUM_SRC-1:0] pend);
      vector_t v;
      v = '0;
      for (int i = `NUM_SRC - 1; i >= 0; i--) begin
         if (pend[i]) begin
            v = vector_t'(`VECTOR_TOP - i);   // Lowest index wins, so it is seen last
         end
      end
      return v;
   endfunction

   function automatic logic [`NUM_SRC-1:0] winnerMask(input logic [`NUM_SRC-1:0] pend);
      return pend & (~pend + 1'b1);           // Keeps only the lowest set bit
   endfunction

   task automatic checkValue(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
      assert (actVal === expVal) else begin
         errCount++;
         $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, expVal, actVal, $time);
      end
   endtask

   // Sample a quarter period after the falling edge, once inputs have settled
   initial begin
      logic [`NUM_SRC-1:0] clrExp;
      modelPend = '0;
      forever begin
         @(negedge MCLK);
         #(PERIOD/4);
         clrExp = intAck ? winnerMask(modelPend) : '0;
         if (rstN) begin
            checkValue("intReq", 32'(|modelPend), 32'(intReq));
            checkValue("intVector", 32'(refVector(modelPend)), 32'(intVector));
            checkValue("intClr", 32'(clrExp), 32'(intClr));
         end
         if (deviceReset) begin
            modelPend = '0;
         end
         else begin
            modelPend = (modelPend | intSrc) & ~clrExp;   // Clear beats a new flag
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic pulseSources(input logic [`NUM_SRC-1:0] mask);
      @(negedge MCLK);
      intSrc = mask;
      @(negedge MCLK);
      intSrc = '0;
   endtask

   task automatic ackOnce();
      @(negedge MCLK);
      intAck = 1'b1;
      @(negedge MCLK);
      intAck = 1'b0;
   endtask

   task automatic waitReq(input logic level, input string testName);
      int n;
      n = 0;
      while (intReq !== level && n < 20) begin
         @(negedge MCLK);
         #(PERIOD/4);
         n++;
      end
      assert (intReq === level) else begin
         errCount++;
         $display("Timed out in %s waiting for intReq to reach %0b", testName, level);
      end
   endtask

   task automatic endTest(input string name);
      testCount++;
      if (errCount == testErrStart) begin
         $display("Test %0d %s ok", testCount, name);
      end
      else begin
         $display("Test %0d %s bad, %0d errors", testCount, name, errCount - testErrStart);
      end
      testErrStart = errCount;
   endtask

   initial begin
      int n;
      void'($urandom(32'hd9a875f4));
      rstN   = 1'b0;
      intAck = 1'b0;
      intSrc = '0;

      repeat (4) begin
         @(negedge MCLK);
         checkValue("deviceReset", 32'(1), 32'(deviceReset));
         intSrc = `NUM_SRC'($urandom);        // Ignored while reset is held
      end
      rstN = 1'b1;
      n = 0;
      while (deviceReset && n < 4 * `RESET_DELAY) begin
         intSrc = `NUM_SRC'($urandom);
         @(negedge MCLK);
         n++;
      end
      intSrc = '0;
      assert (n >= `RESET_DELAY && n <= `RESET_DELAY + 2) else begin
         errCount++;
         $display("deviceReset fell after %0d clocks, outside the stretch window", n);
      end
      endTest("reset stretch");

      repeat (2) @(negedge MCLK);
      #(PERIOD/4);
      checkValue("intReq", 32'(0), 32'(intReq));
      endTest("reset masking");

      for (int k = 0; k < `NUM_SRC; k += 3) begin
         pulseSources(`NUM_SRC'(1) << k);
         waitReq(1'b1, "single source");
         ackOnce();
         waitReq(1'b0, "single source");
      end
      endTest("single source");

      pulseSources(`NUM_SRC'(32'ha6));
      waitReq(1'b1, "priority order");
      repeat (4) ackOnce();                   // One per set bit of the mask
      waitReq(1'b0, "priority order");
      endTest("priority order");

      ackOnce();
      waitReq(1'b0, "stray acknowledge");
      endTest("stray acknowledge");

      repeat (400) begin
         @(negedge MCLK);
         intSrc = `NUM_SRC'($urandom & $urandom & $urandom);
         intAck = ($urandom % 3) == 0;
      end
      @(negedge MCLK);
      intSrc = '0;
      n = 0;
      while (intReq && n < 4 * `NUM_SRC) begin
         intAck = 1'b1;                       // Drain whatever is still pending
         @(negedge MCLK);
         n++;
      end
      intAck = 1'b0;
      assert (!intReq) else begin
         errCount++;
         $display("Pending requests did not drain after random traffic");
      end
      endTest("random traffic");

      $display("Tests %0d, errors %0d", testCount, errCount);
      if (errCount == 0) begin
         $display("*** PASSED ***");
      end
      else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
